/* all.f */
+incdir+include
design/cpu_types_pkg.sv
design/pipeline_pkg.sv
design/pipeline_ifs.sv
design/control_unit.sv
design/register_file.sv
design/alu.sv
design/hazard_unit.sv
design/datapath.sv
design/cpu_top.sv
sim/cpu_properties.sv
sim/cpu_tb.sv

/* Makefile */
# Verilator build for the pipelined core testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= cpu_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: compile run clean

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) include/cpu_defs.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* sim/cpu_tb.sv */
// Testbench for the pipelined core
// instruction and data memory models with 0..3 cycle hit latency,
// directed programs checked against the final data memory
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
   import cpu_types_pkg::*;

   localparam int TIMEOUT = 2000;
   localparam logic [5:0] OPC_ADDIU = 6'h09, OPC_ORI = 6'h0d, OPC_LUI = 6'h0f;
   localparam logic [5:0] OPC_LW = 6'h23, OPC_SW = 6'h2b, OPC_BEQ = 6'h04;
   localparam logic [5:0] OPC_BNE = 6'h05, OPC_J = 6'h02, OPC_JAL = 6'h03;
   localparam word_t HALT_W = 32'hfc00_0000;

   logic  CLK, nRST, imem_ren, ihit, dmem_ren, dmem_wen, dhit, halt;
   word_t imem_addr, imem_data, dmem_addr, dmem_store, dmem_load;

   word_t imem [256];
   word_t dmem [word_t];
   word_t dinit [word_t];   // contents after reset
   word_t expd [word_t];
   word_t prog [$];
   logic [1:0] icnt = 2'd0;   // cycles left until hit
   logic [1:0] dcnt = 2'd0;
   logic  rand_on;
   int    seed;

   cpu_top i_dut (.CLK, .nRST, .imem_addr, .imem_ren, .imem_data, .ihit,
                  .dmem_addr, .dmem_store, .dmem_ren, .dmem_wen, .dmem_load, .dhit, .halt);

   always #50 CLK = ~CLK;

   ////////////////////
   // memory models
   ////////////////////
   function automatic logic [1:0] next_lat();
      int r;
      r = $random(seed);
      return rand_on ? r[1:0] : 2'd0;
   endfunction

   function automatic word_t read_data(input word_t addr);
      return dmem.exists(addr) ? dmem[addr] : ~addr;
   endfunction

   assign imem_data = imem[imem_addr[9:2]];
   assign ihit      = (icnt == 2'd0);
   assign dhit      = (dmem_ren || dmem_wen) && (dcnt == 2'd0);
   assign dmem_load = read_data(dmem_addr);

   always @(posedge CLK) begin
      if (!nRST) begin
         dmem = dinit;
         icnt <= 2'd0;
         dcnt <= 2'd0;
      end else begin
         icnt <= ihit ? next_lat() : icnt - 2'd1;
         if (dmem_wen && dhit)
            dmem[dmem_addr] = dmem_store;
         if (dhit)
            dcnt <= next_lat();
         else if (dmem_ren || dmem_wen)
            dcnt <= dcnt - 2'd1;
      end
   end

   ////////////////////
   // encoders and checks
   ////////////////////
   function automatic word_t r_instr(input int rs, input int rt, input int rd,
                                     input int sh, input int fn);
      return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn[5:0]};
   endfunction

   function automatic word_t i_instr(input logic [5:0] op, input int rs, input int rt,
                                     input int imm);
      return {op, rs[4:0], rt[4:0], imm[15:0]};
   endfunction

   function automatic word_t j_instr(input logic [5:0] op, input int idx);
      return {op, idx[25:0]};
   endfunction

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("Errors found");
      $fatal(1, "test stopped");
   endtask

   task automatic run_program(input string name);
      int cycles;
      for (int i = 0; i < 256; i++)
         imem[i] = (i < prog.size()) ? prog[i] : {6'h3f, 26'(i)};
      @(posedge CLK);
      nRST <= 1'b0;
      repeat (2) @(posedge CLK);
      nRST <= 1'b1;
      cycles = 0;
      while (!halt) begin
         @(posedge CLK);
         cycles++;
         assert (imem_ren)
            else fail_now($sformatf("%s: instruction read enable dropped", name));
         if (cycles >= TIMEOUT)
            fail_now($sformatf("%s: timed out waiting for halt", name));
      end
      // core must stay quiet once halted
      repeat (20) begin
         @(posedge CLK);
         assert (!dmem_wen && halt)
            else fail_now($sformatf("%s: store or halt drop after halt", name));
      end
      foreach (expd[a]) begin
         assert (dmem.exists(a) && dmem[a] == expd[a])
            else fail_now($sformatf("MISMATCH %0t %s: mem[%h] = %h, expected %h",
                                    $time, name, a, read_data(a), expd[a]));
      end
      assert (dmem.size() == expd.size())
         else fail_now($sformatf("%s: store to an unexpected address", name));
   endtask

   ////////////////////
   // directed tests
   ////////////////////
   task automatic alu_chain();
      word_t v [13];
      prog.delete();
      dinit.delete();
      expd.delete();
      v[1]  = 5;
      v[2]  = v[1] + 7;
      v[3]  = v[1] + v[2];
      v[4]  = v[3] - v[1];
      v[5]  = v[3] ^ v[2];
      v[6]  = v[4] | v[5];
      v[7]  = -32'sd3;
      v[8]  = ($signed(v[7]) < $signed(v[1])) ? 1 : 0;
      v[9]  = v[2] << 4;
      v[10] = 32'h1234_0000;
      v[11] = v[10] | 32'habcd;
      v[12] = v[5] & v[3];
      prog.push_back(i_instr(OPC_ADDIU, 0, 1, 5));
      prog.push_back(i_instr(OPC_ADDIU, 1, 2, 7));    // from mem stage
      prog.push_back(r_instr(1, 2, 3, 0, 'h21));      // wb and mem
      prog.push_back(r_instr(3, 1, 4, 0, 'h23));
      prog.push_back(r_instr(3, 2, 5, 0, 'h26));
      prog.push_back(r_instr(4, 5, 6, 0, 'h25));
      prog.push_back(i_instr(OPC_ADDIU, 0, 7, 'hfffd));
      prog.push_back(r_instr(7, 1, 8, 0, 'h2a));
      prog.push_back(r_instr(0, 2, 9, 4, 'h00));
      prog.push_back(i_instr(OPC_LUI, 0, 10, 'h1234));
      prog.push_back(i_instr(OPC_ORI, 10, 11, 'habcd));
      prog.push_back(r_instr(5, 3, 12, 0, 'h24));
      for (int k = 1; k <= 12; k++) begin
         prog.push_back(i_instr(OPC_SW, 0, k, 'h100 + 4 * (k - 1)));
         expd[32'h100 + 4 * (k - 1)] = v[k];
      end
      prog.push_back(HALT_W);
      prog.push_back(i_instr(OPC_SW, 0, 1, 'h1f0));   // never reached
      run_program("alu");
   endtask

   task automatic load_use_pairs();
      prog.delete();
      dinit.delete();
      expd.delete();
      dinit[32'h200] = 32'h11;
      dinit[32'h204] = 32'h22;
      expd = dinit;
      prog.push_back(i_instr(OPC_LW, 0, 1, 'h200));
      prog.push_back(r_instr(1, 1, 2, 0, 'h21));      // use right after load
      prog.push_back(i_instr(OPC_SW, 0, 2, 'h300));
      prog.push_back(i_instr(OPC_LW, 0, 3, 'h204));
      prog.push_back(i_instr(OPC_SW, 0, 3, 'h304));   // load feeds store data
      prog.push_back(i_instr(OPC_LW, 0, 4, 'h200));
      prog.push_back(i_instr(OPC_ADDIU, 4, 5, 1));
      prog.push_back(i_instr(OPC_SW, 0, 5, 'h308));
      prog.push_back(HALT_W);
      expd[32'h300] = 32'h11 + 32'h11;
      expd[32'h304] = 32'h22;
      expd[32'h308] = 32'h11 + 1;
      run_program("load_use");
   endtask

   task automatic branch_paths();
      prog.delete();
      dinit.delete();
      expd.delete();
      prog.push_back(i_instr(OPC_ADDIU, 0, 1, 1));    // 0
      prog.push_back(i_instr(OPC_ADDIU, 0, 2, 1));    // 1
      prog.push_back(i_instr(OPC_BEQ, 1, 2, 2));      // 2 taken to 5
      prog.push_back(i_instr(OPC_SW, 0, 1, 'h400));   // 3 wrong path
      prog.push_back(i_instr(OPC_SW, 0, 1, 'h404));   // 4 wrong path
      prog.push_back(i_instr(OPC_BNE, 1, 2, 1));      // 5 not taken
      prog.push_back(i_instr(OPC_SW, 0, 1, 'h408));   // 6
      prog.push_back(i_instr(OPC_BEQ, 1, 0, 1));      // 7 not taken
      prog.push_back(i_instr(OPC_SW, 0, 2, 'h41c));   // 8
      prog.push_back(i_instr(OPC_BNE, 1, 0, 1));      // 9 taken to 11
      prog.push_back(i_instr(OPC_SW, 0, 1, 'h40c));   // 10 wrong path
      prog.push_back(j_instr(OPC_J, 13));             // 11
      prog.push_back(i_instr(OPC_SW, 0, 1, 'h410));   // 12 wrong path
      prog.push_back(j_instr(OPC_JAL, 16));           // 13
      prog.push_back(i_instr(OPC_SW, 0, 31, 'h414));  // 14 link value
      prog.push_back(j_instr(OPC_J, 19));             // 15
      prog.push_back(i_instr(OPC_ADDIU, 0, 3, 'h55)); // 16
      prog.push_back(i_instr(OPC_SW, 0, 3, 'h418));   // 17
      prog.push_back(r_instr(31, 0, 0, 0, 'h08));     // 18 jr back to 14
      prog.push_back(HALT_W);                         // 19
      expd[32'h408] = 1;
      expd[32'h41c] = 1;
      expd[32'h414] = 13 * 4 + 4;
      expd[32'h418] = 32'h55;
      run_program("branches");
   endtask

   initial begin
      CLK     = 1'b0;
      nRST    = 1'b0;
      rand_on = 1'b0;
      seed    = 32'h3b9f4959;
      // same programs once with ideal hits, once with random latency
      for (int m = 0; m < 2; m++) begin
         rand_on = (m == 1);
         alu_chain();
         load_use_pairs();
         branch_paths();
      end
      $display("No errors");
      $finish;
   end

endmodule

`default_nettype wire

/* sim/cpu_properties.sv */
// Data port and halt properties of the core
// bound to the top level, checks the hit handshake and the halt latch
`timescale 1ns/1ps
`default_nettype none

module cpu_properties (
   input logic                 CLK,
   input logic                 nRST,
   input cpu_types_pkg::word_t dmem_addr,
   input cpu_types_pkg::word_t dmem_store,
   input logic                 dmem_ren,
   input logic                 dmem_wen,
   input logic                 dhit,
   input logic                 halt
);

   // one kind of data access at a time
   a_one_access: assert property (@(posedge CLK) disable iff (!nRST)
      !(dmem_ren && dmem_wen))
      else $error("data read and write requested together");

   a_halt_sticky: assert property (@(posedge CLK) disable iff (!nRST)
      halt |=> halt)
      else $error("halt dropped without reset");

   // waiting access holds its request steady
   a_hold_access: assert property (@(posedge CLK) disable iff (!nRST)
      ((dmem_ren || dmem_wen) && !dhit) |=>
         ($stable(dmem_addr) && $stable(dmem_store)
          && $stable(dmem_ren) && $stable(dmem_wen)))
      else $error("data request changed before dhit");

endmodule

bind cpu_top cpu_properties i_props (.*);

`default_nettype wire

/* design/cpu_top.sv */
// Processor core top level
// five-stage pipeline with separate instruction and data ports,
// each port completing on its hit signal
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
   input  logic                 CLK,
   input  logic                 nRST,
   // instruction port
   output cpu_types_pkg::word_t imem_addr,
   output logic                 imem_ren,
   input  cpu_types_pkg::word_t imem_data,
   input  logic                 ihit,
   // data port
   output cpu_types_pkg::word_t dmem_addr,
   output cpu_types_pkg::word_t dmem_store,
   output logic                 dmem_ren,
   output logic                 dmem_wen,
   input  cpu_types_pkg::word_t dmem_load,
   input  logic                 dhit,
   output logic                 halt
);

   datapath i_dp (
      .CLK,
      .nRST,
      .imem_addr,
      .imem_ren,
      .imem_data,
      .ihit,
      .dmem_addr,
      .dmem_store,
      .dmem_ren,
      .dmem_wen,
      .dmem_load,
      .dhit,
      .halt
   );

endmodule

`default_nettype wire

/* design/datapath.sv */
// Five-stage datapath
// PC, the four stage latches, forwarding and operand muxes,
// branch resolution in execute, writeback select and the halt latch
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module datapath (
   input  logic                 CLK,
   input  logic                 nRST,
   output cpu_types_pkg::word_t imem_addr,
   output logic                 imem_ren,
   input  cpu_types_pkg::word_t imem_data,
   input  logic                 ihit,
   output cpu_types_pkg::word_t dmem_addr,
   output cpu_types_pkg::word_t dmem_store,
   output logic                 dmem_ren,
   output logic                 dmem_wen,
   input  cpu_types_pkg::word_t dmem_load,
   input  logic                 dhit,
   output logic                 halt
);
   import cpu_types_pkg::*;
   import pipeline_pkg::*;

   word_t      pc, fd_instr, fd_pcp4, rdat1, rdat2, imm_ext;
   logic       fetch_stop;   // HALT has left decode
   // decode/execute
   logic       e_regwr, e_memrd, e_memwr, e_halt;
   pc_src_t    e_pc_src;
   br_kind_t   e_br_kind;
   res_src_t   e_res_src;
   dst_sel_t   e_dst_sel;
   aluop_t     e_alu_op;
   alu_b_src_t e_alu_b_src;
   word_t      e_pcp4, e_rdat1, e_rdat2, e_imm;
   regbits_t   e_rs, e_rt, e_rd, e_dst;
   logic [4:0] e_shamt;
   logic [25:0] e_jaddr;
   word_t      a_fwd, b_fwd, alu_b, alu_res, e_target;
   logic       taken, redirect;
   // execute/memory and memory/writeback
   logic       m_regwr, m_memrd, m_memwr, m_halt, w_regwr, w_halt;
   res_src_t   m_res_src, w_res_src;
   regbits_t   m_dst, w_dst;
   word_t      m_alu, m_store, m_pcp4, m_fwd, w_alu, w_load, w_pcp4, w_wdat;

   decode_if dif ();
   hazard_if hif ();

   control_unit  i_cu (.dif(dif.cu));
   hazard_unit   i_hz (.hif(hif.hz));
   register_file i_rf (.CLK, .nRST, .rsel1(dif.rs), .rsel2(dif.rt), .wsel(w_dst),
                       .wdat(w_wdat), .wen(w_regwr), .rdat1, .rdat2);
   alu           i_alu (.a(a_fwd), .b(alu_b), .shamt(e_shamt), .op(e_alu_op), .res(alu_res));

   ////////////////////
   // fetch
   ////////////////////
   assign imem_addr = pc;
   assign imem_ren  = 1'b1;

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         pc         <= `CPU_PC_INIT;
         fetch_stop <= 1'b0;
         fd_instr   <= '0;   // zero word decodes as nop
         fd_pcp4    <= '0;
      end else if (hif.fd_en) begin
         if (!fetch_stop)
            pc <= redirect ? e_target : pc + 4;
         if (dif.halt && !hif.fd_flush)
            fetch_stop <= 1'b1;
         fd_instr <= (hif.fd_flush || fetch_stop || dif.halt) ? '0 : imem_data;
         fd_pcp4  <= pc + 4;
      end
   end

   ////////////////////
   // decode
   ////////////////////
   assign dif.instr = fd_instr;
   assign imm_ext   = dif.extop ? {{16{dif.imm16[15]}}, dif.imm16} : {16'h0, dif.imm16};

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         e_regwr   <= 1'b0;
         e_memrd   <= 1'b0;
         e_memwr   <= 1'b0;
         e_halt    <= 1'b0;
         e_pc_src  <= PC_SEQ;
         e_br_kind <= BR_NONE;
      end else if (hif.de_en) begin
         e_regwr   <= dif.regwr && !hif.de_flush;
         e_memrd   <= dif.memrd && !hif.de_flush;
         e_memwr   <= dif.memwr && !hif.de_flush;
         e_halt    <= dif.halt && !hif.de_flush;
         e_pc_src  <= hif.de_flush ? PC_SEQ : dif.pc_src;
         e_br_kind <= hif.de_flush ? BR_NONE : dif.br_kind;
      end
   end

   always_ff @(posedge CLK) begin
      if (hif.de_en) begin
         e_res_src   <= dif.res_src;
         e_dst_sel   <= dif.dst_sel;
         e_alu_op    <= dif.alu_op;
         e_alu_b_src <= dif.alu_b_src;
         e_pcp4      <= fd_pcp4;
         e_rdat1     <= rdat1;
         e_rdat2     <= rdat2;
         e_imm       <= imm_ext;
         e_rs        <= dif.rs;
         e_rt        <= dif.rt;
         e_rd        <= dif.rd;
         e_shamt     <= dif.shamt;
         e_jaddr     <= fd_instr[25:0];
      end
   end

   ////////////////////
   // execute
   ////////////////////
   always_comb begin
      case (hif.fwd_a)
         FWD_MEM: a_fwd = m_fwd;
         FWD_WB:  a_fwd = w_wdat;
         default: a_fwd = e_rdat1;
      endcase
      case (hif.fwd_b)
         FWD_MEM: b_fwd = m_fwd;
         FWD_WB:  b_fwd = w_wdat;
         default: b_fwd = e_rdat2;
      endcase
      case (e_alu_b_src)
         B_IMM:   alu_b = e_imm;
         B_UPPER: alu_b = {e_imm[15:0], 16'h0};
         default: alu_b = b_fwd;
      endcase
      case (e_dst_sel)
         DST_RT:   e_dst = e_rt;
         DST_RA31: e_dst = 5'd31;
         default:  e_dst = e_rd;
      endcase
      case (e_pc_src)
         PC_BRANCH: e_target = e_pcp4 + {e_imm[29:0], 2'b00};
         PC_JUMP:   e_target = {e_pcp4[31:28], e_jaddr, 2'b00};
         default:   e_target = a_fwd;   // jr
      endcase
   end

   // compare on forwarded operands, not the ALU output
   assign taken    = (e_br_kind == BR_EQ) ? (a_fwd == b_fwd)
                   : (e_br_kind == BR_NE) ? (a_fwd != b_fwd) : 1'b0;
   assign redirect = (e_pc_src == PC_BRANCH) ? taken : (e_pc_src != PC_SEQ);

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         m_regwr <= 1'b0;
         m_memrd <= 1'b0;
         m_memwr <= 1'b0;
         m_halt  <= 1'b0;
      end else if (hif.em_en) begin
         m_regwr <= e_regwr;
         m_memrd <= e_memrd;
         m_memwr <= e_memwr;
         m_halt  <= e_halt;
      end
   end

   always_ff @(posedge CLK) begin
      if (hif.em_en) begin
         m_res_src <= e_res_src;
         m_dst     <= e_dst;
         m_alu     <= alu_res;
         m_store   <= b_fwd;   // sw data
         m_pcp4    <= e_pcp4;
      end
   end

   ////////////////////
   // memory
   ////////////////////
   assign m_fwd      = (m_res_src == RES_LINK) ? m_pcp4 : m_alu;
   assign dmem_addr  = m_alu;
   assign dmem_store = m_store;
   assign dmem_ren   = m_memrd;
   assign dmem_wen   = m_memwr;

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         w_regwr <= 1'b0;
         w_halt  <= 1'b0;
      end else if (hif.mw_en) begin
         w_regwr <= m_regwr;
         w_halt  <= m_halt;
      end
   end

   always_ff @(posedge CLK) begin
      if (hif.mw_en) begin
         w_res_src <= m_res_src;
         w_dst     <= m_dst;
         w_alu     <= m_alu;
         w_load    <= dmem_load;
         w_pcp4    <= m_pcp4;
      end
   end

   ////////////////////
   // writeback
   ////////////////////
   always_comb begin
      case (w_res_src)
         RES_MEM:  w_wdat = w_load;
         RES_LINK: w_wdat = w_pcp4;   // jal link
         default:  w_wdat = w_alu;
      endcase
   end

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST)
         halt <= 1'b0;
      else if (w_halt)
         halt <= 1'b1;   // sticky until reset
   end

   // hazard unit inputs
   assign hif.d_rs     = dif.rs;
   assign hif.d_rt     = dif.rt;
   assign hif.e_rs     = e_rs;
   assign hif.e_rt     = e_rt;
   assign hif.e_memrd  = e_memrd;
   assign hif.e_dst    = e_dst;
   assign hif.e_regwr  = e_regwr;
   assign hif.m_dst    = m_dst;
   assign hif.m_regwr  = m_regwr;
   assign hif.w_dst    = w_dst;
   assign hif.w_regwr  = w_regwr;
   assign hif.redirect = redirect;
   assign hif.ihit     = ihit;
   assign hif.dhit     = dhit;
   assign hif.m_memacc = m_memrd || m_memwr;

endmodule

`default_nettype wire

/* design/hazard_unit.sv */
// Hazard unit
// picks forwarding sources, stalls on load-use, flushes on redirect
// and freezes the pipe while either memory port waits for its hit
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
   hazard_if.hz hif
);
   import cpu_types_pkg::*;
   import pipeline_pkg::*;

   logic load_use;
   logic dwait;
   logic freeze;

   // newest producer wins, r0 always comes from the register file
   function automatic fwd_sel_t pick_src(input regbits_t src);
      if (src == '0)
         return FWD_REGFILE;
      if (hif.m_regwr && hif.m_dst == src)
         return FWD_MEM;
      if (hif.w_regwr && hif.w_dst == src)
         return FWD_WB;
      return FWD_REGFILE;
   endfunction

   always_comb begin
      hif.fwd_a = pick_src(hif.e_rs);
      hif.fwd_b = pick_src(hif.e_rt);
   end

   // load in execute feeding the instruction in decode
   assign load_use = hif.e_memrd && hif.e_regwr && (hif.e_dst != '0)
                     && (hif.e_dst == hif.d_rs || hif.e_dst == hif.d_rt);

   assign dwait  = hif.m_memacc && !hif.dhit;
   assign freeze = !hif.ihit || dwait;

   ////////////////////
   // stage enables
   ////////////////////
   assign hif.pc_en    = !freeze && (hif.redirect || !load_use);
   assign hif.fd_en    = hif.pc_en;
   assign hif.fd_flush = hif.redirect;
   assign hif.de_en    = !freeze;
   assign hif.de_flush = hif.redirect || load_use;   // bubble into execute
   assign hif.em_en    = !freeze;
   assign hif.mw_en    = !freeze;   // wb holds so its forward stays valid

endmodule

`default_nettype wire

/* design/alu.sv */
// Integer ALU
// add/sub, logic ops, signed compare, left shift and B pass-through
`timescale 1ns/1ps
`default_nettype none

module alu (
   input  cpu_types_pkg::word_t  a,
   input  cpu_types_pkg::word_t  b,
   input  logic [4:0]            shamt,
   input  cpu_types_pkg::aluop_t op,
   output cpu_types_pkg::word_t  res
);
   import cpu_types_pkg::*;

   always_comb begin
      case (op)
         ALU_ADD:   res = a + b;
         ALU_SUB:   res = a - b;
         ALU_AND:   res = a & b;
         ALU_OR:    res = a | b;
         ALU_XOR:   res = a ^ b;
         ALU_SLT:   res = word_t'($signed(a) < $signed(b));
         ALU_SLL:   res = b << shamt;   // shifts rt
         ALU_PASSB: res = b;            // lui
         default:   res = '0;
      endcase
   end

endmodule

`default_nettype wire

/* design/register_file.sv */
// 32 x 32 register file
// r0 reads zero, writes land on the clock edge and bypass to same-cycle reads
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module register_file (
   input  logic                    CLK,
   input  logic                    nRST,
   input  cpu_types_pkg::regbits_t rsel1,
   input  cpu_types_pkg::regbits_t rsel2,
   input  cpu_types_pkg::regbits_t wsel,
   input  cpu_types_pkg::word_t    wdat,
   input  logic                    wen,
   output cpu_types_pkg::word_t    rdat1,
   output cpu_types_pkg::word_t    rdat2
);
   import cpu_types_pkg::*;

   word_t regs [`CPU_NREGS];
   logic  wr_live;   // a real write this cycle

   assign wr_live = wen && (wsel != '0);

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         for (int i = 0; i < `CPU_NREGS; i++)
            regs[i] <= '0;
      end else if (wr_live) begin
         regs[wsel] <= wdat;
      end
   end

   assign rdat1 = (wr_live && wsel == rsel1) ? wdat : regs[rsel1];
   assign rdat2 = (wr_live && wsel == rsel2) ? wdat : regs[rsel2];

endmodule

`default_nettype wire

/* design/control_unit.sv */
// Instruction decoder
// splits the fetched word into fields and control for the later stages
`timescale 1ns/1ps
`default_nettype none

module control_unit (
   decode_if.cu dif
);
   import cpu_types_pkg::*;
   import pipeline_pkg::*;

   always_comb begin
      dif.rs        = dif.instr[25:21];
      dif.rt        = dif.instr[20:16];
      dif.rd        = dif.instr[15:11];
      dif.shamt     = dif.instr[10:6];
      dif.imm16     = dif.instr[15:0];
      // defaults describe a nop
      dif.extop     = 1'b1;
      dif.alu_op    = ALU_ADD;
      dif.alu_b_src = B_REG;
      dif.dst_sel   = DST_RD;
      dif.res_src   = RES_ALU;
      dif.pc_src    = PC_SEQ;
      dif.br_kind   = BR_NONE;
      dif.regwr     = 1'b0;
      dif.memrd     = 1'b0;
      dif.memwr     = 1'b0;
      dif.halt      = 1'b0;

      case (opcode_t'(dif.instr[31:26]))
         OP_RTYPE: begin
            dif.regwr = 1'b1;
            case (funct_t'(dif.instr[5:0]))
               FN_ADDU: dif.alu_op = ALU_ADD;
               FN_SUBU: dif.alu_op = ALU_SUB;
               FN_AND:  dif.alu_op = ALU_AND;
               FN_OR:   dif.alu_op = ALU_OR;
               FN_XOR:  dif.alu_op = ALU_XOR;
               FN_SLT:  dif.alu_op = ALU_SLT;
               FN_SLL:  dif.alu_op = ALU_SLL;
               FN_JR: begin
                  dif.regwr  = 1'b0;
                  dif.pc_src = PC_JREG;
               end
               default: dif.regwr = 1'b0;   // unknown funct acts as nop
            endcase
         end
         OP_ADDIU: begin
            dif.regwr     = 1'b1;
            dif.alu_b_src = B_IMM;
            dif.dst_sel   = DST_RT;
         end
         OP_ORI: begin
            dif.regwr     = 1'b1;
            dif.extop     = 1'b0;   // logical imm is zero extended
            dif.alu_op    = ALU_OR;
            dif.alu_b_src = B_IMM;
            dif.dst_sel   = DST_RT;
         end
         OP_LUI: begin
            dif.regwr     = 1'b1;
            dif.alu_op    = ALU_PASSB;
            dif.alu_b_src = B_UPPER;
            dif.dst_sel   = DST_RT;
         end
         OP_LW: begin
            dif.regwr     = 1'b1;
            dif.memrd     = 1'b1;
            dif.alu_b_src = B_IMM;
            dif.dst_sel   = DST_RT;
            dif.res_src   = RES_MEM;
         end
         OP_SW: begin
            dif.memwr     = 1'b1;
            dif.alu_b_src = B_IMM;
         end
         OP_BEQ: begin
            dif.pc_src  = PC_BRANCH;
            dif.br_kind = BR_EQ;
         end
         OP_BNE: begin
            dif.pc_src  = PC_BRANCH;
            dif.br_kind = BR_NE;
         end
         OP_J:  dif.pc_src = PC_JUMP;
         OP_JAL: begin
            dif.pc_src  = PC_JUMP;
            dif.regwr   = 1'b1;
            dif.dst_sel = DST_RA31;
            dif.res_src = RES_LINK;
         end
         default: dif.halt = 1'b1;   // HALT or unknown opcode
      endcase
   end

endmodule

`default_nettype wire

/* design/pipeline_ifs.sv */
// Internal interfaces of the core
// decode_if links decoder and datapath, hazard_if links hazard unit and datapath
`timescale 1ns/1ps
`default_nettype none

interface decode_if;
   import cpu_types_pkg::*;
   import pipeline_pkg::*;

   word_t      instr;
   regbits_t   rs, rt, rd;
   logic [4:0] shamt;
   logic [15:0] imm16;
   logic       extop;   // 1 = sign extend
   logic       regwr, memrd, memwr, halt;
   aluop_t     alu_op;
   alu_b_src_t alu_b_src;
   dst_sel_t   dst_sel;
   res_src_t   res_src;
   pc_src_t    pc_src;
   br_kind_t   br_kind;

   modport cu (input instr, output rs, rt, rd, shamt, imm16, extop, alu_op, alu_b_src,
               dst_sel, res_src, pc_src, br_kind, regwr, memrd, memwr, halt);
   modport dp (output instr, input rs, rt, rd, shamt, imm16, extop, alu_op, alu_b_src,
               dst_sel, res_src, pc_src, br_kind, regwr, memrd, memwr, halt);
endinterface

interface hazard_if;
   import cpu_types_pkg::*;
   import pipeline_pkg::*;

   regbits_t d_rs, d_rt, e_rs, e_rt, e_dst, m_dst, w_dst;
   logic     e_memrd, e_regwr, m_regwr, w_regwr;
   logic     redirect;   // taken branch or jump in execute
   logic     ihit, dhit, m_memacc;
   fwd_sel_t fwd_a, fwd_b;
   logic     pc_en, fd_en, fd_flush, de_en, de_flush, em_en, mw_en;

   modport hz (input d_rs, d_rt, e_rs, e_rt, e_memrd, e_dst, e_regwr, m_dst, m_regwr,
               w_dst, w_regwr, redirect, ihit, dhit, m_memacc,
               output fwd_a, fwd_b, pc_en, fd_en, fd_flush, de_en, de_flush, em_en, mw_en);
   modport dp (output d_rs, d_rt, e_rs, e_rt, e_memrd, e_dst, e_regwr, m_dst, m_regwr,
               w_dst, w_regwr, redirect, ihit, dhit, m_memacc,
               input fwd_a, fwd_b, pc_en, fd_en, fd_flush, de_en, de_flush, em_en, mw_en);
endinterface

`default_nettype wire

/* design/pipeline_pkg.sv */
// Pipeline control types
// mux selects shared by decode, hazard logic and the datapath
`default_nettype none

package pipeline_pkg;

   // writeback source
   typedef enum logic [1:0] {
      RES_ALU  = 2'd0,
      RES_MEM  = 2'd1,
      RES_LINK = 2'd2   // pc + 4 for jal
   } res_src_t;

   typedef enum logic [1:0] {
      DST_RD   = 2'd0,
      DST_RT   = 2'd1,
      DST_RA31 = 2'd2
   } dst_sel_t;

   typedef enum logic [1:0] {
      PC_SEQ, PC_BRANCH, PC_JUMP, PC_JREG
   } pc_src_t;

   typedef enum logic [1:0] {
      BR_NONE, BR_EQ, BR_NE
   } br_kind_t;

   // operand source in execute
   typedef enum logic [1:0] {
      FWD_REGFILE, FWD_MEM, FWD_WB
   } fwd_sel_t;

   typedef enum logic [1:0] {
      B_REG, B_IMM, B_UPPER   // upper = imm16 << 16
   } alu_b_src_t;

endpackage

`default_nettype wire

/* design/cpu_types_pkg.sv */
// ISA types for the MIPS-like core
// words, register indices, opcodes, funct codes and ALU operations
`default_nettype none
`include "cpu_defs.svh"

package cpu_types_pkg;

   typedef logic [`CPU_WORD_W-1:0] word_t;
   typedef logic [`CPU_REG_W-1:0]  regbits_t;

   // primary opcode, instr[31:26]
   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00,
      OP_J     = 6'h02,
      OP_JAL   = 6'h03,
      OP_BEQ   = 6'h04,
      OP_BNE   = 6'h05,
      OP_ADDIU = 6'h09,
      OP_ORI   = 6'h0d,
      OP_LUI   = 6'h0f,
      OP_LW    = 6'h23,
      OP_SW    = 6'h2b,
      OP_HALT  = 6'h3f   // all ones
   } opcode_t;

   // r-type function, instr[5:0]
   typedef enum logic [5:0] {
      FN_SLL  = 6'h00,
      FN_JR   = 6'h08,
      FN_ADDU = 6'h21,
      FN_SUBU = 6'h23,
      FN_AND  = 6'h24,
      FN_OR   = 6'h25,
      FN_XOR  = 6'h26,
      FN_SLT  = 6'h2a
   } funct_t;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_PASSB
   } aluop_t;

endpackage

`default_nettype wire

/* include/cpu_defs.svh */
// CPU core parameters
// word and register file geometry plus the reset vector
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data path and address width
`define CPU_WORD_W  32

// general purpose register file
`define CPU_NREGS   32
`define CPU_REG_W   5   // log2 of CPU_NREGS

// first fetch address after reset
`define CPU_PC_INIT 32'h0000_0000

`endif
